/* src/cpu_config.svh */
// Widths, depths and opcode values shared by the RTL and the testbench
// Opcodes not listed here execute as no-ops
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

`define DATA_WIDTH      16
`define INSTR_WIDTH     32
`define REG_ADDR_WIDTH  5
`define IMEM_ADDR_WIDTH 8
`define DMEM_ADDR_WIDTH 6

`define NUM_REGS        32
`define IMEM_DEPTH      256
`define DMEM_DEPTH      64

`define OP_ADD   4'd0
`define OP_SUB   4'd1
`define OP_AND   4'd2
`define OP_OR    4'd3
`define OP_XOR   4'd4
`define OP_SHL   4'd5
`define OP_ADDI  4'd6
`define OP_LOAD  4'd7
`define OP_STORE 4'd8
`define OP_BZ    4'd9
`define OP_HALT  4'd15

`endif

/* src/cpuPkg.sv */
// Vector types and the run-state encoding for the pipelined CPU
// Widths come from the config header
`include "cpu_config.svh"

package cpuPkg;

	// Operand or result
	typedef logic [`DATA_WIDTH-1:0] dataWord;

	// Instruction: op 31..28, rd 27..23, ra 22..18, rb 17..13, imm 15..0
	typedef logic [`INSTR_WIDTH-1:0] instrWord;

	typedef logic [`REG_ADDR_WIDTH-1:0] regAddr;

	// Instruction and data memory addresses
	typedef logic [`IMEM_ADDR_WIDTH-1:0] pcAddr;
	typedef logic [`DMEM_ADDR_WIDTH-1:0] dmemAddr;

	typedef logic [3:0] opCode;

	// Fetch state: loading, running, or stopped after HALT
	typedef enum logic [1:0] {
		stIdle,
		stRun,
		stHalted
	} runState;

endpackage

/* src/fetchUnit.sv */
// Program load port, instruction memory, PC and fetch register
// Loads are taken only in stIdle or stHalted; start restarts loading and the PC at 0
// Only forward branches are expected, so a program always reaches its HALT
`timescale 1ns/1ps
`include "cpu_config.svh"

module fetchUnit
	import cpuPkg::*;
(
	input  logic     clk,
	input  logic     rstN,
	input  logic     progValid,
	input  instrWord progData,
	output logic     progReady,
	input  logic     start,
	input  logic     stall,
	input  logic     branchTaken,
	input  pcAddr    branchTarget,
	input  logic     haltSeen,
	output logic     fetchValid,
	output instrWord fetchInstr,
	output pcAddr    fetchPc,
	output logic     halted
);

	runState  state;
	pcAddr    loadAddr;
	pcAddr    pc;
	instrWord imem [`IMEM_DEPTH];

	assign progReady = (state == stIdle) || (state == stHalted);
	assign halted    = (state == stHalted);

	// Program load writes one word per handshake
	always_ff @(posedge clk) begin
		if (progValid && progReady)
			imem[loadAddr] <= progData;
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state      <= stIdle;
			loadAddr   <= '0;
			pc         <= '0;
			fetchValid <= 1'b0;
		end else begin
			case (state)
				stIdle, stHalted: begin
					fetchValid <= 1'b0;
					if (start) begin
						state    <= stRun;
						loadAddr <= '0;
						pc       <= '0;
					end else if (progValid) begin
						loadAddr <= loadAddr + 1'b1;
					end
				end
				stRun: begin
					// HALT in execute ends the program and drops anything fetched after it
					if (haltSeen) begin
						state      <= stHalted;
						fetchValid <= 1'b0;
					end else if (!stall) begin
						if (branchTaken) begin
							pc         <= branchTarget;
							fetchValid <= 1'b0;
						end else begin
							pc         <= pc + 1'b1;
							fetchValid <= 1'b1;
						end
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

	// Fetch register payload
	always_ff @(posedge clk) begin
		if (state == stRun && !stall) begin
			fetchInstr <= imem[pc];
			fetchPc    <= pc;
		end
	end

endmodule

/* src/regFile.sv */
// 32 x 16 register file, two combinational read ports and one write port
// Register 0 reads as zero and ignores writes
`timescale 1ns/1ps
`include "cpu_config.svh"

module regFile
	import cpuPkg::*;
(
	input  logic    clk,
	input  logic    rstN,
	input  regAddr  rdAddrA,
	input  regAddr  rdAddrB,
	output dataWord rdDataA,
	output dataWord rdDataB,
	input  logic    wrEn,
	input  regAddr  wrAddr,
	input  dataWord wrData
);

	dataWord regs [`NUM_REGS];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < `NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wrEn && wrAddr != '0) begin
			regs[wrAddr] <= wrData;
		end
	end

	// Entry 0 is never written, so it stays zero after reset
	assign rdDataA = regs[rdAddrA];
	assign rdDataB = regs[rdAddrB];

endmodule

/* src/decodeStage.sv */
// Decode and register read, with forwarding from execute
// STORE reads rd on the second port, other ops read rb
// Non-writing ops carry destination 0, so execute never commits them
`timescale 1ns/1ps
`include "cpu_config.svh"

module decodeStage
	import cpuPkg::*;
(
	input  logic     clk,
	input  logic     rstN,
	input  logic     stall,
	input  logic     flush,
	input  logic     fetchValid,
	input  instrWord fetchInstr,
	output regAddr   rdAddrA,
	output regAddr   rdAddrB,
	input  dataWord  rdDataA,
	input  dataWord  rdDataB,
	input  logic     fwdEn,
	input  regAddr   fwdAddr,
	input  dataWord  fwdData,
	output logic     exValid,
	output opCode    exOp,
	output regAddr   exRd,
	output dataWord  exA,
	output dataWord  exB,
	output dataWord  exStoreVal,
	output dataWord  exImm,
	output pcAddr    exPc,
	input  pcAddr    fetchPc
);

	opCode   op;
	regAddr  rd;
	regAddr  ra;
	regAddr  rb;
	dataWord imm;
	dataWord opA;
	dataWord opB;
	logic    writesReg;

	assign op  = fetchInstr[31:28];
	assign rd  = fetchInstr[27:23];
	assign ra  = fetchInstr[22:18];
	assign rb  = fetchInstr[17:13];
	assign imm = fetchInstr[15:0];

	assign rdAddrA = ra;
	assign rdAddrB = (op == `OP_STORE) ? rd : rb;

	// Result being written this cycle is not yet in the register file
	assign opA = (fwdEn && fwdAddr != '0 && fwdAddr == rdAddrA) ? fwdData : rdDataA;
	assign opB = (fwdEn && fwdAddr != '0 && fwdAddr == rdAddrB) ? fwdData : rdDataB;

	always_comb begin
		case (op)
			`OP_ADD, `OP_SUB, `OP_AND, `OP_OR, `OP_XOR,
			`OP_SHL, `OP_ADDI, `OP_LOAD: writesReg = 1'b1;
			default:                     writesReg = 1'b0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rstN)
			exValid <= 1'b0;
		else if (!stall)
			exValid <= fetchValid && !flush;
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			exOp       <= op;
			exRd       <= writesReg ? rd : '0;
			exA        <= opA;
			exB        <= opB;
			exStoreVal <= (op == `OP_STORE) ? opB : '0;
			exImm      <= imm;
			exPc       <= fetchPc;
		end
	end

endmodule

/* src/executeStage.sv */
// Execute, memory access and writeback control, all combinational
// Writeback is held off while stalled so a frozen instruction commits once
`timescale 1ns/1ps
`include "cpu_config.svh"

module executeStage
	import cpuPkg::*;
(
	input  logic    exValid,
	input  opCode   exOp,
	input  regAddr  exRd,
	input  dataWord exA,
	input  dataWord exB,
	input  dataWord exStoreVal,
	input  dataWord exImm,
	input  pcAddr   exPc,
	input  dataWord loadData,
	input  logic    stall,
	output logic    wrEn,
	output regAddr  wrAddr,
	output dataWord wrData,
	output logic    memRead,
	output logic    memWrite,
	output dmemAddr memAddr,
	output dataWord memData,
	output logic    branchTaken,
	output pcAddr   branchTarget,
	output logic    haltSeen
);

	dataWord effAddr;

	// LOAD and STORE address is ra + imm, low bits only
	assign effAddr = exA + exImm;
	assign memAddr = effAddr[`DMEM_ADDR_WIDTH-1:0];
	assign memData = exStoreVal;

	assign memRead  = exValid && exOp == `OP_LOAD;
	assign memWrite = exValid && exOp == `OP_STORE;

	always_comb begin
		case (exOp)
			`OP_ADD:  wrData = exA + exB;
			`OP_SUB:  wrData = exA - exB;
			`OP_AND:  wrData = exA & exB;
			`OP_OR:   wrData = exA | exB;
			`OP_XOR:  wrData = exA ^ exB;
			`OP_SHL:  wrData = exA << exB[3:0];
			`OP_ADDI: wrData = effAddr;
			`OP_LOAD: wrData = loadData;
			default:  wrData = '0;
		endcase
	end

	// Destination 0 marks an op that writes nothing
	assign wrEn   = exValid && !stall && exRd != '0;
	assign wrAddr = exRd;

	// BZ target is relative to the next instruction
	assign branchTaken  = exValid && exOp == `OP_BZ && exA == '0;
	assign branchTarget = exPc + 1'b1 + exImm[`IMEM_ADDR_WIDTH-1:0];
	assign haltSeen     = exValid && exOp == `OP_HALT;

endmodule

/* src/dataMemory.sv */
// 64-word data memory with combinational read and a valid/ready store port
// A store reaches the array only when the handshake completes
// stall holds the pipeline while a store waits for storeReady
`timescale 1ns/1ps
`include "cpu_config.svh"

module dataMemory
	import cpuPkg::*;
(
	input  logic    clk,
	input  logic    rstN,
	input  logic    memRead,
	input  logic    memWrite,
	input  dmemAddr memAddr,
	input  dataWord memData,
	output dataWord loadData,
	output logic    storeValid,
	output dmemAddr storeAddr,
	output dataWord storeData,
	input  logic    storeReady,
	output logic    stall
);

	dataWord mem [`DMEM_DEPTH];
	logic    storeFire;

	// The store sits frozen in execute, so the port holds steady until it is taken
	assign storeValid = memWrite;
	assign storeAddr  = memAddr;
	assign storeData  = memData;
	assign storeFire  = storeValid && storeReady;
	assign stall      = storeValid && !storeReady;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < `DMEM_DEPTH; i++)
				mem[i] <= '0;
		end else if (storeFire) begin
			mem[storeAddr] <= storeData;
		end
	end

	assign loadData = memRead ? mem[memAddr] : '0;

endmodule

/* src/pipeCpu.sv */
// Three-stage pipelined CPU: fetch, decode and register read, execute with memory
// A taken BZ or a HALT in execute flushes the younger instructions
`timescale 1ns/1ps

module pipeCpu
	import cpuPkg::*;
(
	input  logic     clk,
	input  logic     rstN,
	input  logic     progValid,
	input  instrWord progData,
	output logic     progReady,
	input  logic     start,
	output logic     storeValid,
	output dmemAddr  storeAddr,
	output dataWord  storeData,
	input  logic     storeReady,
	output logic     halted
);

	logic     stall;
	logic     flush;
	logic     fetchValid;
	instrWord fetchInstr;
	pcAddr    fetchPc;
	regAddr   rdAddrA;
	regAddr   rdAddrB;
	dataWord  rdDataA;
	dataWord  rdDataB;
	logic     exValid;
	opCode    exOp;
	regAddr   exRd;
	dataWord  exA;
	dataWord  exB;
	dataWord  exStoreVal;
	dataWord  exImm;
	pcAddr    exPc;
	logic     wrEn;
	regAddr   wrAddr;
	dataWord  wrData;
	logic     memRead;
	logic     memWrite;
	dmemAddr  memAddr;
	dataWord  memData;
	dataWord  loadData;
	logic     branchTaken;
	pcAddr    branchTarget;
	logic     haltSeen;

	assign flush = branchTaken || haltSeen;

	fetchUnit fetchUnit_i (
		.clk          (clk),
		.rstN         (rstN),
		.progValid    (progValid),
		.progData     (progData),
		.progReady    (progReady),
		.start        (start),
		.stall        (stall),
		.branchTaken  (branchTaken),
		.branchTarget (branchTarget),
		.haltSeen     (haltSeen),
		.fetchValid   (fetchValid),
		.fetchInstr   (fetchInstr),
		.fetchPc      (fetchPc),
		.halted       (halted)
	);

	decodeStage decodeStage_i (
		.clk        (clk),
		.rstN       (rstN),
		.stall      (stall),
		.flush      (flush),
		.fetchValid (fetchValid),
		.fetchInstr (fetchInstr),
		.rdAddrA    (rdAddrA),
		.rdAddrB    (rdAddrB),
		.rdDataA    (rdDataA),
		.rdDataB    (rdDataB),
		.fwdEn      (wrEn),
		.fwdAddr    (wrAddr),
		.fwdData    (wrData),
		.exValid    (exValid),
		.exOp       (exOp),
		.exRd       (exRd),
		.exA        (exA),
		.exB        (exB),
		.exStoreVal (exStoreVal),
		.exImm      (exImm),
		.exPc       (exPc),
		.fetchPc    (fetchPc)
	);

	regFile regFile_i (
		.clk     (clk),
		.rstN    (rstN),
		.rdAddrA (rdAddrA),
		.rdAddrB (rdAddrB),
		.rdDataA (rdDataA),
		.rdDataB (rdDataB),
		.wrEn    (wrEn),
		.wrAddr  (wrAddr),
		.wrData  (wrData)
	);

	executeStage executeStage_i (
		.exValid      (exValid),
		.exOp         (exOp),
		.exRd         (exRd),
		.exA          (exA),
		.exB          (exB),
		.exStoreVal   (exStoreVal),
		.exImm        (exImm),
		.exPc         (exPc),
		.loadData     (loadData),
		.stall        (stall),
		.wrEn         (wrEn),
		.wrAddr       (wrAddr),
		.wrData       (wrData),
		.memRead      (memRead),
		.memWrite     (memWrite),
		.memAddr      (memAddr),
		.memData      (memData),
		.branchTaken  (branchTaken),
		.branchTarget (branchTarget),
		.haltSeen     (haltSeen)
	);

	dataMemory dataMemory_i (
		.clk        (clk),
		.rstN       (rstN),
		.memRead    (memRead),
		.memWrite   (memWrite),
		.memAddr    (memAddr),
		.memData    (memData),
		.loadData   (loadData),
		.storeValid (storeValid),
		.storeAddr  (storeAddr),
		.storeData  (storeData),
		.storeReady (storeReady),
		.stall      (stall)
	);

endmodule

/* test/tbClock.sv */
// Testbench clock and reset, 10 ns period
// rstN is held low for 10 rising edges and released 1 ns after the last one
`timescale 1ns/1ps

module tbClock (
	output logic clk,
	output logic rstN
);

	localparam int halfPeriod  = 5;
	localparam int resetCycles = 10;

	initial begin
		clk = 1'b0;
		forever #halfPeriod clk = ~clk;
	end

	initial begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		#1 rstN = 1'b1;
	end

endmodule

/* test/pipeCpuTb.sv */
// Random programs run on the CPU and on an ISA model kept in the testbench
// Register and memory state carry over between programs in both, as after one reset
// Only forward branches are generated, so every program reaches its HALT
`timescale 1ns/1ps
`include "cpu_config.svh"

module pipeCpuTb
	import cpuPkg::*;
();

	localparam int numPrograms = 30;

	logic     clk;
	logic     rstN;
	logic     progValid;
	instrWord progData;
	logic     progReady;
	logic     start;
	logic     storeValid;
	dmemAddr  storeAddr;
	dataWord  storeData;
	logic     storeReady;
	logic     halted;

	logic [31:0] lfsrState;
	instrWord    prog [`IMEM_DEPTH];
	int          progLen;
	dataWord     modelRegs [`NUM_REGS];
	dataWord     modelMem [`DMEM_DEPTH];
	dmemAddr     expAddr [$];
	dataWord     expData [$];
	int          storeIdx;
	logic        holdPending;
	dmemAddr     heldAddr;
	dataWord     heldData;
	int          cycleBudget = 40;
	int          cyclesUsed;

	tbClock tbClock_i (
		.clk  (clk),
		.rstN (rstN)
	);

	pipeCpu pipeCpu_i (
		.clk        (clk),
		.rstN       (rstN),
		.progValid  (progValid),
		.progData   (progData),
		.progReady  (progReady),
		.start      (start),
		.storeValid (storeValid),
		.storeAddr  (storeAddr),
		.storeData  (storeData),
		.storeReady (storeReady),
		.halted     (halted)
	);

	// Fibonacci LFSR x^32 + x^22 + x^2 + x + 1, one step per bit returned
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			lfsrState = {lfsrState[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	// Registers 0..7 only, so dependencies and r0 turn up often
	function automatic regAddr pickReg();
		return regAddr'(randBits(3));
	endfunction

	function automatic instrWord encodeReg(opCode op, regAddr rd, regAddr ra, regAddr rb);
		return {op, rd, ra, rb, 13'd0};
	endfunction

	function automatic instrWord encodeImm(opCode op, regAddr rd, regAddr ra, dataWord imm);
		return {op, rd, ra, 2'b00, imm};
	endfunction

	task automatic stopOnError(input string msg);
		$display("%s", msg);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic checkData(input string sigName, input dataWord got, input dataWord exp);
		if (got !== exp)
			stopOnError($sformatf("FAILED at %0d ns: %s is %h, expected %h",
				$time, sigName, got, exp));
	endtask

	task automatic checkAddr(input string sigName, input dmemAddr got, input dmemAddr exp);
		if (got !== exp)
			stopOnError($sformatf("FAILED at %0d ns: %s is %h, expected %h",
				$time, sigName, got, exp));
	endtask

	task automatic genProgram();
		int         body;
		int         k;
		logic [3:0] pick;
		regAddr     rd;
		regAddr     ra;
		regAddr     rb;
		dataWord    imm;
		body = 8 + int'(randBits(5));
		for (int i = 0; i < body; i++) begin
			pick = 4'(randBits(4));
			rd = pickReg();
			ra = pickReg();
			case (pick)
				4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5: begin
					rb = pickReg();
					prog[i] = encodeReg(opCode'(pick), rd, ra, rb);
				end
				4'd9, 4'd10, 4'd11, 4'd12: begin
					// Few addresses so loads meet earlier stores, +64 checks the wrap
					if (randBits(1) == 32'd1)
						ra = '0;
					imm = dataWord'(randBits(3));
					if (randBits(1) == 32'd1)
						imm = imm + 16'd64;
					prog[i] = encodeImm((pick == 4'd9) ? `OP_LOAD : `OP_STORE, rd, ra, imm);
				end
				4'd13, 4'd14: begin
					if (randBits(2) == 32'd0)
						ra = '0;
					k = int'(randBits(2));
					// Target never passes the final HALT
					if (k > body - 1 - i)
						k = body - 1 - i;
					prog[i] = encodeImm(`OP_BZ, '0, ra, dataWord'(k));
				end
				default:
					prog[i] = encodeImm(`OP_ADDI, rd, ra, dataWord'(randBits(16)));
			endcase
		end
		prog[body] = {`OP_HALT, 28'd0};
		progLen = body + 1;
	endtask

	function automatic void writeReg(input regAddr rd, input dataWord v);
		if (rd != '0)
			modelRegs[rd] = v;
	endfunction

	// ISA model, fills the expected store list
	task automatic runModel();
		pcAddr    pc;
		int       steps;
		logic     done;
		instrWord ins;
		regAddr   rd;
		dataWord  a;
		dataWord  b;
		dataWord  imm;
		dmemAddr  addr;
		expAddr.delete();
		expData.delete();
		pc = '0;
		steps = 0;
		done = 1'b0;
		while (!done && steps < 1000) begin
			ins = prog[pc];
			rd = ins[27:23];
			a = modelRegs[ins[22:18]];
			b = modelRegs[ins[17:13]];
			imm = ins[15:0];
			addr = dmemAddr'(a + imm);
			pc = pc + 8'd1;
			case (ins[31:28])
				`OP_ADD:  writeReg(rd, a + b);
				`OP_SUB:  writeReg(rd, a - b);
				`OP_AND:  writeReg(rd, a & b);
				`OP_OR:   writeReg(rd, a | b);
				`OP_XOR:  writeReg(rd, a ^ b);
				`OP_SHL:  writeReg(rd, a << b[3:0]);
				`OP_ADDI: writeReg(rd, a + imm);
				`OP_LOAD: writeReg(rd, modelMem[addr]);
				`OP_STORE: begin
					expAddr.push_back(addr);
					expData.push_back(modelRegs[rd]);
					modelMem[addr] = modelRegs[rd];
				end
				`OP_BZ: begin
					if (a == '0)
						pc = pc + imm[7:0];
				end
				`OP_HALT: done = 1'b1;
				default: ;
			endcase
			steps++;
		end
		if (!done)
			stopOnError("ISA model did not reach HALT");
	endtask

	// Inputs change 1 ns after a rising edge
	task automatic nextCycle();
		@(posedge clk);
		#1;
	endtask

	task automatic loadProgram();
		int gap;
		for (int i = 0; i < progLen; i++) begin
			gap = int'(randBits(2));
			nextCycle();
			progValid = 1'b0;
			repeat (gap) nextCycle();
			progValid = 1'b1;
			progData  = prog[i];
			@(negedge clk);
			if (progReady !== 1'b1)
				stopOnError($sformatf("progReady low while loading word %0d", i));
		end
		nextCycle();
		progValid = 1'b0;
	endtask

	// Called at a falling edge, where the port and storeReady are settled
	task automatic checkStorePort();
		if (holdPending) begin
			if (storeValid !== 1'b1)
				stopOnError("storeValid dropped before the store was taken");
			checkAddr("storeAddr", storeAddr, heldAddr);
			checkData("storeData", storeData, heldData);
		end
		if (storeValid === 1'b1 && storeReady === 1'b1) begin
			if (storeIdx >= expAddr.size()) begin
				stopOnError($sformatf("unexpected store to %h after %0d expected stores",
					storeAddr, expAddr.size()));
			end else begin
				checkAddr("storeAddr", storeAddr, expAddr[storeIdx]);
				checkData("storeData", storeData, expData[storeIdx]);
				storeIdx++;
			end
		end
		holdPending = (storeValid === 1'b1) && (storeReady !== 1'b1);
		heldAddr = storeAddr;
		heldData = storeData;
	endtask

	task automatic runProgram();
		storeIdx = 0;
		holdPending = 1'b0;
		start = 1'b1;
		nextCycle();
		start = 1'b0;
		storeReady = (randBits(2) != 32'd0);
		@(negedge clk);
		if (progReady !== 1'b0 || halted !== 1'b0)
			stopOnError("progReady or halted still high after start");
		do begin
			nextCycle();
			storeReady = (randBits(2) != 32'd0);
			@(negedge clk);
			checkStorePort();
		end while (halted !== 1'b1);
		if (storeIdx != expAddr.size())
			stopOnError($sformatf("halted after %0d of %0d expected stores",
				storeIdx, expAddr.size()));
	endtask

	initial begin : watchdog
		cyclesUsed = 0;
		while (cyclesUsed < cycleBudget) begin
			@(posedge clk);
			cyclesUsed++;
		end
		stopOnError($sformatf("watchdog expired after %0d cycles", cyclesUsed));
	end

	initial begin : mainSeq
		lfsrState  = 32'h93d1;
		progValid  = 1'b0;
		progData   = '0;
		start      = 1'b0;
		storeReady = 1'b0;
		for (int i = 0; i < `NUM_REGS; i++)
			modelRegs[i] = '0;
		for (int i = 0; i < `DMEM_DEPTH; i++)
			modelMem[i] = '0;
		@(posedge rstN);
		@(negedge clk);
		if (progReady !== 1'b1 || halted !== 1'b0 || storeValid !== 1'b0)
			stopOnError("wrong progReady, halted or storeValid after reset");
		for (int t = 0; t < numPrograms; t++) begin
			// Every tenth run reloads and reruns the previous program
			if (t % 10 != 9)
				genProgram();
			runModel();
			// 200 cycles per instruction, plus a load of up to 4 cycles per word
			cycleBudget += 204 * progLen + 8;
			loadProgram();
			runProgram();
		end
		$display("all tests passed");
		$finish;
	end

endmodule

/* sources.f */
+incdir+src
src/cpuPkg.sv
src/fetchUnit.sv
src/regFile.sv
src/decodeStage.sv
src/executeStage.sv
src/dataMemory.sv
src/pipeCpu.sv
test/tbClock.sv
test/pipeCpuTb.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module pipeCpuTb \
	-f sources.f --Mdir obj_dir -o pipeCpuSim
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
	echo "Verilator build failed with status $buildStatus"
	exit 1
fi

simOut=$(./obj_dir/pipeCpuSim 2>&1)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if echo "$simOut" | grep -qx "all tests passed"; then
	exit 0
fi
echo "Pass message not found in the simulation output"
exit 1
